// File: source/lane_pkg.sv
// Image and ROI sizes, Hough sizes, trig tables, vector types and peak search states
package lane_pkg;

    // Frame geometry
    localparam int IMAGE_WIDTH  = 32;
    localparam int IMAGE_HEIGHT = 16;
    localparam int FRAME_PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;

    // Inclusive search window, in frame coordinates
    localparam int ROI_START_X = 4;
    localparam int ROI_END_X   = 27;
    localparam int ROI_START_Y = 4;
    localparam int ROI_END_Y   = 15;

    // Lowest gray level taken as an edge
    localparam int EDGE_THRESHOLD = 128;

    // Hough space, theta index k stands for k * 22.5 degrees
    localparam int THETA_STEPS = 8;
    localparam int LEFT_THETAS = 4;
    localparam int RHO_OFFSET  = 32;
    localparam int RHO_BINS    = 64;
    localparam int ACCUM_DEPTH = THETA_STEPS * RHO_BINS;

    localparam int FIFO_DEPTH = 8;

    // Trig values scaled by 256
    localparam int TRIG_FRACTION_BITS = 8;

    localparam logic signed [11:0] COS_TABLE [THETA_STEPS] = '{
        12'sd256, 12'sd237, 12'sd181, 12'sd98,
        12'sd0, -12'sd98, -12'sd181, -12'sd237
    };

    localparam logic signed [11:0] SIN_TABLE [THETA_STEPS] = '{
        12'sd0, 12'sd98, 12'sd181, 12'sd237,
        12'sd256, 12'sd237, 12'sd181, 12'sd98
    };

    // Red in the top byte
    typedef logic [23:0]        rgb_t;
    typedef logic [7:0]         gray_t;
    typedef logic signed [5:0]  coord_t;
    typedef logic [2:0]         theta_t;
    typedef logic signed [6:0]  rho_t;
    // Theta index in the top three bits, rho bin below
    typedef logic [8:0]         accum_addr_t;
    typedef logic [7:0]         votes_t;

    typedef enum logic [1:0] {
        CLEARING,
        IDLE,
        SCANNING,
        REPORT
    } peak_state_t;

endpackage

// File: source/pixel_fifo.sv
// First-word-fall-through FIFO holding incoming RGB pixels
module pixel_fifo import lane_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic wr_en,
    input  rgb_t din,
    input  logic rd_en,
    output logic full,
    output rgb_t dout,
    output logic empty
);

    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
    localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

    rgb_t                  mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_write;
    logic                  do_read;

    assign full  = (count == COUNT_BITS'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Oldest entry is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/pixel_decode.sv
// Grayscale conversion, raster position tracking, ROI test and edge threshold
module pixel_decode import lane_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  rgb_t   fifo_data,
    input  logic   fifo_empty,
    input  logic   vote_ready,
    output logic   fifo_rd_en,
    output logic   edge_valid,
    output logic   edge_is_edge,
    output coord_t edge_x,
    output coord_t edge_y,
    output logic   frame_end
);

    logic [4:0] col;
    logic [3:0] row;
    logic [9:0] channel_sum;
    gray_t      gray;
    logic       in_roi;
    logic       last_col;
    logic       last_row;

    // Take a new pixel whenever the output slot is free or being consumed
    assign fifo_rd_en = !fifo_empty && (!edge_valid || vote_ready);

    assign channel_sum = {2'b00, fifo_data[23:16]}
                       + {2'b00, fifo_data[15:8]}
                       + {2'b00, fifo_data[7:0]};
    assign gray = gray_t'(channel_sum / 10'd3);

    assign in_roi = (col >= 5'(ROI_START_X)) && (col <= 5'(ROI_END_X))
                 && (row >= 4'(ROI_START_Y)) && (row <= 4'(ROI_END_Y));

    assign last_col = (col == 5'(IMAGE_WIDTH - 1));
    assign last_row = (row == 4'(IMAGE_HEIGHT - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            col          <= '0;
            row          <= '0;
            edge_valid   <= 1'b0;
            edge_is_edge <= 1'b0;
            frame_end    <= 1'b0;
        end else if (fifo_rd_en) begin
            edge_valid   <= 1'b1;
            edge_is_edge <= in_roi && (gray >= gray_t'(EDGE_THRESHOLD));
            frame_end    <= last_col && last_row;
            if (last_col) begin
                col <= '0;
                row <= last_row ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end else if (vote_ready) begin
            edge_valid <= 1'b0;
            frame_end  <= 1'b0;
        end
    end

    // Position relative to the ROI origin
    always_ff @(posedge clock) begin
        if (fifo_rd_en) begin
            edge_x <= coord_t'({1'b0, col}) - coord_t'(ROI_START_X);
            edge_y <= coord_t'({2'b00, row}) - coord_t'(ROI_START_Y);
        end
    end

endmodule

// File: source/hough_vote.sv
// Theta sweep per edge pixel with a read-increment-write voting pipeline
module hough_vote import lane_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        edge_valid,
    input  logic        edge_is_edge,
    input  coord_t      edge_x,
    input  coord_t      edge_y,
    input  logic        frame_end,
    input  logic        clear_busy,
    input  votes_t      rd_votes,
    output logic        vote_ready,
    output accum_addr_t rd_addr,
    output logic        wr_en,
    output accum_addr_t wr_addr,
    output votes_t      wr_votes,
    output logic        scan_start
);

    logic               busy;
    logic               end_pending;
    theta_t             theta_q;
    coord_t             x_q;
    coord_t             y_q;
    logic               accept;
    logic               accept_edge;
    logic               issue;
    theta_t             cur_theta;
    coord_t             cur_x;
    coord_t             cur_y;
    logic signed [18:0] rho_sum;
    rho_t               rho;
    logic [5:0]         rho_bin;
    logic               s1_valid;
    accum_addr_t        s1_addr;

    assign vote_ready  = !busy && !end_pending && !scan_start && !clear_busy;
    assign accept      = edge_valid && vote_ready;
    assign accept_edge = accept && edge_is_edge;

    // Theta 0 goes out in the accept cycle, the other seven from the latched pixel
    assign issue     = busy || accept_edge;
    assign cur_theta = busy ? theta_q : '0;
    assign cur_x     = busy ? x_q : edge_x;
    assign cur_y     = busy ? y_q : edge_y;

    assign rho_sum = cur_x * COS_TABLE[cur_theta] + cur_y * SIN_TABLE[cur_theta];
    assign rho     = rho_t'(rho_sum >>> TRIG_FRACTION_BITS);
    assign rho_bin = 6'(rho + 7'(RHO_OFFSET));
    assign rd_addr = {cur_theta, rho_bin};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            theta_q     <= '0;
            end_pending <= 1'b0;
            scan_start  <= 1'b0;
            s1_valid    <= 1'b0;
            wr_en       <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            if (accept_edge) begin
                busy    <= 1'b1;
                theta_q <= theta_t'(1);
            end else if (busy) begin
                theta_q <= theta_q + 1'b1;
                if (theta_q == theta_t'(THETA_STEPS - 1)) begin
                    busy <= 1'b0;
                end
            end
            if (accept && frame_end) begin
                end_pending <= 1'b1;
            end
            // Start the scan only once the last write has landed
            if (end_pending && !busy && !s1_valid && !wr_en) begin
                end_pending <= 1'b0;
                scan_start  <= 1'b1;
            end
            s1_valid <= issue;
            wr_en    <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (accept_edge) begin
            x_q <= edge_x;
            y_q <= edge_y;
        end
        s1_addr  <= rd_addr;
        wr_addr  <= s1_addr;
        // Saturate at full scale
        wr_votes <= (rd_votes == '1) ? rd_votes : rd_votes + 1'b1;
    end

endmodule

// File: source/accum_ram.sv
// Hough accumulator memory with a registered read port and a write port
module accum_ram import lane_pkg::*; (
    input  logic        clock,
    input  accum_addr_t rd_addr,
    input  logic        wr_en,
    input  accum_addr_t wr_addr,
    input  votes_t      wr_votes,
    output votes_t      rd_votes
);

    votes_t mem [ACCUM_DEPTH];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_votes;
        end
    end

    // Data appears one cycle after the address
    always_ff @(posedge clock) begin
        rd_votes <= mem[rd_addr];
    end

endmodule

// File: source/peak_search.sv
// Accumulator clear pass, left and right peak scan, result registers and done pulse
module peak_search import lane_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        scan_start,
    input  votes_t      ram_votes,
    output logic        clear_busy,
    output accum_addr_t scan_addr,
    output logic        clear_wr_en,
    output accum_addr_t clear_addr,
    output logic        hough_done,
    output rho_t        left_rho,
    output rho_t        right_rho,
    output theta_t      left_theta,
    output theta_t      right_theta
);

    // Empty halves fall back to rho 0 at the first theta of the half
    localparam accum_addr_t LEFT_INIT  = {theta_t'(0), 6'(RHO_OFFSET)};
    localparam accum_addr_t RIGHT_INIT = {theta_t'(LEFT_THETAS), 6'(RHO_OFFSET)};

    peak_state_t state;
    accum_addr_t cnt;
    logic        cnt_last;
    logic        cmp_valid;
    accum_addr_t cmp_addr;
    votes_t      left_votes;
    votes_t      right_votes;
    accum_addr_t left_addr;
    accum_addr_t right_addr;
    votes_t      left_votes_n;
    votes_t      right_votes_n;
    accum_addr_t left_addr_n;
    accum_addr_t right_addr_n;

    assign cnt_last   = (cnt == accum_addr_t'(ACCUM_DEPTH - 1));
    assign clear_busy = (state != IDLE);
    assign scan_addr  = cnt;

    // Zero each entry one cycle after its read
    assign clear_wr_en = (state == CLEARING) || cmp_valid;
    assign clear_addr  = (state == CLEARING) ? cnt : cmp_addr;

    // Only a strictly larger count wins, so ties keep the earliest entry
    always_comb begin
        left_votes_n  = left_votes;
        left_addr_n   = left_addr;
        right_votes_n = right_votes;
        right_addr_n  = right_addr;
        if (cmp_valid) begin
            if (cmp_addr[8:6] < theta_t'(LEFT_THETAS)) begin
                if (ram_votes > left_votes) begin
                    left_votes_n = ram_votes;
                    left_addr_n  = cmp_addr;
                end
            end else if (ram_votes > right_votes) begin
                right_votes_n = ram_votes;
                right_addr_n  = cmp_addr;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= CLEARING;
            cnt         <= '0;
            cmp_valid   <= 1'b0;
            hough_done  <= 1'b0;
            left_rho    <= '0;
            right_rho   <= '0;
            left_theta  <= theta_t'(0);
            right_theta <= theta_t'(LEFT_THETAS);
        end else begin
            hough_done <= 1'b0;
            cmp_valid  <= (state == SCANNING);
            case (state)
                CLEARING: begin
                    cnt <= cnt + 1'b1;
                    if (cnt_last) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    cnt <= '0;
                    if (scan_start) begin
                        state <= SCANNING;
                    end
                end
                SCANNING: begin
                    cnt <= cnt + 1'b1;
                    if (cnt_last) begin
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    // Last entry is still being compared in this cycle
                    state       <= IDLE;
                    hough_done  <= 1'b1;
                    left_rho    <= rho_t'({1'b0, left_addr_n[5:0]}) - rho_t'(RHO_OFFSET);
                    right_rho   <= rho_t'({1'b0, right_addr_n[5:0]}) - rho_t'(RHO_OFFSET);
                    left_theta  <= left_addr_n[8:6];
                    right_theta <= right_addr_n[8:6];
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        cmp_addr <= cnt;
        if (scan_start) begin
            left_votes  <= '0;
            right_votes <= '0;
            left_addr   <= LEFT_INIT;
            right_addr  <= RIGHT_INIT;
        end else begin
            left_votes  <= left_votes_n;
            right_votes <= right_votes_n;
            left_addr   <= left_addr_n;
            right_addr  <= right_addr_n;
        end
    end

endmodule

// File: source/lane_hough_top.sv
// Lane finder top level with pixel FIFO, decode, voting, accumulator and peak search
module lane_hough_top import lane_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   pixel_wr_en,
    input  rgb_t   pixel_data,
    output logic   pixel_full,
    output logic   hough_done,
    output rho_t   left_rho,
    output rho_t   right_rho,
    output theta_t left_theta,
    output theta_t right_theta
);

    rgb_t        fifo_data;
    logic        fifo_empty;
    logic        fifo_rd_en;
    logic        edge_valid;
    logic        edge_is_edge;
    coord_t      edge_x;
    coord_t      edge_y;
    logic        frame_end;
    logic        vote_ready;
    accum_addr_t vote_rd_addr;
    logic        vote_wr_en;
    accum_addr_t vote_wr_addr;
    votes_t      vote_wr_votes;
    logic        scan_start;
    logic        clear_busy;
    accum_addr_t scan_addr;
    logic        clear_wr_en;
    accum_addr_t clear_addr;
    accum_addr_t ram_rd_addr;
    logic        ram_wr_en;
    accum_addr_t ram_wr_addr;
    votes_t      ram_wr_votes;
    votes_t      ram_rd_votes;

    pixel_fifo pixel_fifo_inst (
        .clock (clock),
        .reset (reset),
        .wr_en (pixel_wr_en),
        .din   (pixel_data),
        .rd_en (fifo_rd_en),
        .full  (pixel_full),
        .dout  (fifo_data),
        .empty (fifo_empty)
    );

    pixel_decode pixel_decode_inst (
        .clock        (clock),
        .reset        (reset),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .vote_ready   (vote_ready),
        .fifo_rd_en   (fifo_rd_en),
        .edge_valid   (edge_valid),
        .edge_is_edge (edge_is_edge),
        .edge_x       (edge_x),
        .edge_y       (edge_y),
        .frame_end    (frame_end)
    );

    hough_vote hough_vote_inst (
        .clock        (clock),
        .reset        (reset),
        .edge_valid   (edge_valid),
        .edge_is_edge (edge_is_edge),
        .edge_x       (edge_x),
        .edge_y       (edge_y),
        .frame_end    (frame_end),
        .clear_busy   (clear_busy),
        .rd_votes     (ram_rd_votes),
        .vote_ready   (vote_ready),
        .rd_addr      (vote_rd_addr),
        .wr_en        (vote_wr_en),
        .wr_addr      (vote_wr_addr),
        .wr_votes     (vote_wr_votes),
        .scan_start   (scan_start)
    );

    // Peak search owns the RAM through its clear, scan and report cycles
    assign ram_rd_addr  = clear_busy ? scan_addr : vote_rd_addr;
    assign ram_wr_en    = clear_busy ? clear_wr_en : vote_wr_en;
    assign ram_wr_addr  = clear_busy ? clear_addr : vote_wr_addr;
    assign ram_wr_votes = clear_busy ? '0 : vote_wr_votes;

    accum_ram accum_ram_inst (
        .clock    (clock),
        .rd_addr  (ram_rd_addr),
        .wr_en    (ram_wr_en),
        .wr_addr  (ram_wr_addr),
        .wr_votes (ram_wr_votes),
        .rd_votes (ram_rd_votes)
    );

    peak_search peak_search_inst (
        .clock       (clock),
        .reset       (reset),
        .scan_start  (scan_start),
        .ram_votes   (ram_rd_votes),
        .clear_busy  (clear_busy),
        .scan_addr   (scan_addr),
        .clear_wr_en (clear_wr_en),
        .clear_addr  (clear_addr),
        .hough_done  (hough_done),
        .left_rho    (left_rho),
        .right_rho   (right_rho),
        .left_theta  (left_theta),
        .right_theta (right_theta)
    );

endmodule

// File: verification/lane_hough_tb.sv
// Lane finder testbench with clock, reset, stimulus reader, frame driver and result checks
module lane_hough_tb import lane_pkg::*; ();

    localparam int CLOCK_PERIOD = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 4;
    localparam int STIM_WORDS   = 256;
    localparam int FULL_TIMEOUT = 1000;
    localparam int DONE_TIMEOUT = 4000;

    logic   clock;
    logic   reset;
    logic   pixel_wr_en;
    rgb_t   pixel_data;
    logic   pixel_full;
    logic   hough_done;
    rho_t   left_rho;
    rho_t   right_rho;
    theta_t left_theta;
    theta_t right_theta;

    logic [31:0] stim_mem [STIM_WORDS];
    rgb_t        frame_pixels [FRAME_PIXELS];
    integer      seed;
    int          word_ptr;
    logic        full_seen;

    lane_hough_top lane_hough_top_inst (
        .clock       (clock),
        .reset       (reset),
        .pixel_wr_en (pixel_wr_en),
        .pixel_data  (pixel_data),
        .pixel_full  (pixel_full),
        .hough_done  (hough_done),
        .left_rho    (left_rho),
        .right_rho   (right_rho),
        .left_theta  (left_theta),
        .right_theta (right_theta)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    // One pixel into the FIFO, holding back while it is full
    task automatic send_pixel(input rgb_t value);
        int waited;
        waited = 0;
        while (pixel_full) begin
            full_seen   = 1'b1;
            pixel_wr_en = 1'b0;
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
            if (waited > FULL_TIMEOUT) begin
                stop_run($sformatf("Timeout at time %0t: pixel_full stayed high for %0d cycles",
                                   $time, FULL_TIMEOUT));
            end
        end
        pixel_data  = value;
        pixel_wr_en = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    // Occasional gaps of one to four cycles
    task automatic insert_idle();
        logic [31:0] r;
        int          idle;
        r    = $random(seed);
        idle = (r[2:0] == 3'd0) ? int'(r[4:3]) + 1 : 0;
        if (idle > 0) begin
            pixel_wr_en = 1'b0;
            repeat (idle) begin
                @(posedge clock);
                #DRIVE_DELAY;
            end
        end
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (!hough_done) begin
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
            if (waited > DONE_TIMEOUT) begin
                stop_run($sformatf("Timeout at time %0t: no hough_done within %0d cycles",
                                   $time, DONE_TIMEOUT));
            end
        end
    endtask

    task automatic run_frame(input int frame_index);
        logic [31:0] mode;
        rgb_t        background;
        int          edge_count;
        logic [31:0] position;
        logic [31:0] expected [4];
        int          i;

        mode       = stim_mem[word_ptr];
        background = stim_mem[word_ptr + 1][23:0];
        edge_count = int'(stim_mem[word_ptr + 2]);
        word_ptr   = word_ptr + 3;

        // Edge pixels painted over the background, then sent in raster order
        for (i = 0; i < FRAME_PIXELS; i++) begin
            frame_pixels[i] = background;
        end
        for (i = 0; i < edge_count; i++) begin
            position = stim_mem[word_ptr];
            frame_pixels[int'(position[7:0]) * IMAGE_WIDTH + int'(position[15:8])] =
                stim_mem[word_ptr + 1][23:0];
            word_ptr = word_ptr + 2;
        end
        for (i = 0; i < 4; i++) begin
            expected[i] = stim_mem[word_ptr + i];
        end
        word_ptr = word_ptr + 4;

        full_seen = 1'b0;
        for (i = 0; i < FRAME_PIXELS; i++) begin
            send_pixel(frame_pixels[i]);
            if (mode == 32'd0) begin
                insert_idle();
            end
        end
        pixel_wr_en = 1'b0;

        wait_for_done();
        check_value($sformatf("frame %0d left_rho", frame_index),
                    {25'd0, left_rho}, expected[0]);
        check_value($sformatf("frame %0d left_theta", frame_index),
                    {29'd0, left_theta}, expected[1]);
        check_value($sformatf("frame %0d right_rho", frame_index),
                    {25'd0, right_rho}, expected[2]);
        check_value($sformatf("frame %0d right_theta", frame_index),
                    {29'd0, right_theta}, expected[3]);
        if (mode != 32'd0) begin
            check_value($sformatf("frame %0d pixel_full seen", frame_index),
                        {31'd0, full_seen}, 32'd1);
        end

        // Done lasts a single cycle
        @(posedge clock);
        #DRIVE_DELAY;
        check_value($sformatf("frame %0d hough_done after pulse", frame_index),
                    {31'd0, hough_done}, 32'd0);
    endtask

    initial begin
        int frame_count;
        int f;

        seed        = 32'h3a9a;
        reset       = 1'b1;
        pixel_wr_en = 1'b0;
        pixel_data  = '0;
        full_seen   = 1'b0;
        word_ptr    = 1;

        $readmemh("verification/hough_stimulus.txt", stim_mem);
        frame_count = int'(stim_mem[0]);
        if ($isunknown(stim_mem[0]) || frame_count == 0) begin
            stop_run("Stimulus file is missing or holds no frames");
        end

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        for (f = 0; f < frame_count; f++) begin
            run_frame(f);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verification/hough_stimulus.txt
// Frame: mode (0 random idle cycles, 1 back-to-back writes), background RGB, edge pixel count,
// then pairs of position (col * 100h + row) and RGB, then left rho, left theta, right rho, right theta
6
// Dark frame, both halves empty
0 000000 0
00 0 00 4
// Diagonal inside the ROI, same brightness outside it
0 101010 b
0404 ffffff 0505 ffffff 0606 ffffff
0707 ffffff 0808 ffffff 0909 ffffff
0000 ffffff 0101 ffffff 0202 ffffff
0303 ffffff 1e0e ffffff
00 0 00 6
// Gray 128 at two pixels, gray 127 at three
0 202020 5
0907 ff8100 090a 808080
0b05 ff8000 0b06 7f8080 0b08 807f80
05 0 03 4
// Two vertical and two horizontal lines of equal length
0 303030 18
0e04 c0c0c0 0e05 c0c0c0 0e06 c0c0c0 0e07 c0c0c0 0e08 c0c0c0 0e09 c0c0c0
1404 ffffff 1405 ffffff 1406 ffffff 1407 ffffff 1408 ffffff 1409 ffffff
040d 90a0b0 050d 90a0b0 060d 90a0b0 070d 90a0b0 080d 90a0b0 090d 90a0b0
160f e0e0e0 170f e0e0e0 180f e0e0e0 190f e0e0e0 1a0f e0e0e0 1b0f e0e0e0
0a 0 09 4
// Short vertical line, right peak at negative rho
0 000000 4
0704 ffffff 0705 ffffff 0706 ffffff 0707 ffffff
03 0 7d 7
// Back-to-back writes with a short horizontal line
1 404040 6
0806 f0f0f0 0906 f0f0f0 0a06 f0f0f0 0b06 f0f0f0 0c06 f0f0f0 0d06 f0f0f0
04 3 02 4

// File: sources.f
source/lane_pkg.sv
source/pixel_fifo.sv
source/pixel_decode.sv
source/hough_vote.sv
source/accum_ram.sv
source/peak_search.sv
source/lane_hough_top.sv
verification/lane_hough_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the lane finder testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing -Wno-fatal --top-module lane_hough_tb -f sources.f \
    -o lane_hough_sim > "$LOG" 2>&1 \
    && ./obj_dir/lane_hough_sim >> "$LOG" 2>&1 \
    || echo "SIMULATION FAILED" >> "$LOG"
cat "$LOG"
grep -q "SIMULATION FAILED" "$LOG" && exit 1
exit 0
